// ==== bus_pkg.sv ====
package bus_pkg;

  // ==========================================================
  // Memory bus widths
  // ==========================================================
  localparam int DATA_BITS = 32;
  localparam int ADDR_BITS = 32;

  // ==========================================================
  // Backing memory geometry and timing
  // ==========================================================
  localparam int MEM_WORDS     = 1024;
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
  // Idle cycles between the request strobe and the first beat
  localparam int MEM_LATENCY   = 3;
  localparam int LAT_BITS      = $clog2(MEM_LATENCY + 1);

  // Line request, address is line aligned
  typedef struct packed {
    logic                 valid;
    logic [ADDR_BITS-1:0] addr;
  } mem_req_t;

  // One response beat
  typedef struct packed {
    logic                 valid;
    logic                 last;
    logic [DATA_BITS-1:0] data;
  } mem_resp_t;

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

  // ==========================================================
  // Cache geometry
  // ==========================================================
  localparam int LINE_WORDS  = 4;
  localparam int WORD_BITS   = $clog2(LINE_WORDS);
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = 4;
  localparam int LINES       = 1 << INDEX_BITS;
  localparam int TAG_BITS    = 24;

  // Address field positions
  localparam int WORD_LSB  = OFFSET_BITS - WORD_BITS;
  localparam int INDEX_LSB = OFFSET_BITS;
  localparam int TAG_LSB   = OFFSET_BITS + INDEX_BITS;

  // ==========================================================
  // Storage types
  // ==========================================================
  typedef logic [TAG_BITS-1:0] tag_t;

  // Word 0 sits in the lowest slot
  typedef logic [LINE_WORDS-1:0][bus_pkg::DATA_BITS-1:0] line_t;

  // ==========================================================
  // Controller
  // ==========================================================
  typedef enum logic [1:0] {
    IDLE,
    CHK,
    RMISS
  } icache_state_t;

  // Performance counters
  localparam int CNT_BITS = 32;

endpackage

// ==== cache_sram.sv ====
module cache_sram #(
  parameter type entry_t = logic
) (
  input  logic                             clk,
  input  logic [cache_pkg::INDEX_BITS-1:0] index,
  input  logic                             write,
  input  entry_t                           wdata,
  output entry_t                           rdata
);

  import cache_pkg::*;

  entry_t mem [LINES];

  // One access per cycle, read data one cycle later
  always_ff @(posedge clk) begin
    if (write) begin
      mem[index] <= wdata;
    end
    rdata <= mem[index];
  end

endmodule

// ==== icache.sv ====
module icache (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           core_req,
  input  logic [bus_pkg::ADDR_BITS-1:0]  core_addr,
  output logic                           core_wait,
  output logic [bus_pkg::DATA_BITS-1:0]  core_out,
  output bus_pkg::mem_req_t              mem_req,
  input  logic                           mem_grant,
  input  bus_pkg::mem_resp_t             mem_resp,
  output logic [cache_pkg::CNT_BITS-1:0] hit_count,
  output logic [cache_pkg::CNT_BITS-1:0] miss_count,
  output logic [cache_pkg::CNT_BITS-1:0] req_count
);

  import bus_pkg::*;
  import cache_pkg::*;

  icache_state_t state, next_state;

  logic [ADDR_BITS-1:0]  addr_r;
  logic [INDEX_BITS-1:0] index;
  logic [INDEX_BITS-1:0] index_in;
  logic [WORD_BITS-1:0]  word_sel;
  logic [LINES-1:0]      valid;

  tag_t  tag_r;
  tag_t  tag_rdata;
  line_t data_rdata;
  line_t line_r;
  line_t fill_line;

  logic hit;
  logic fill_done;
  logic take_req;

  // ==========================================================
  // Request capture
  // ==========================================================
  assign index_in = core_addr[INDEX_LSB +: INDEX_BITS];
  assign take_req = (state == IDLE) && core_req;

  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      addr_r <= core_addr;
    end
  end

  assign tag_r    = addr_r[TAG_LSB +: TAG_BITS];
  assign word_sel = addr_r[WORD_LSB +: WORD_BITS];

  // Incoming address in IDLE so tag and data are ready in CHK
  assign index = (state == IDLE) ? index_in : addr_r[INDEX_LSB +: INDEX_BITS];

  // ==========================================================
  // Controller
  // ==========================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  assign hit       = (tag_rdata == tag_r);
  assign fill_done = (state == RMISS) && mem_resp.valid && mem_resp.last;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (core_req) begin
          // No tag check needed for an empty line
          next_state = valid[index_in] ? CHK : RMISS;
        end
      end
      CHK:     next_state = hit ? IDLE : RMISS;
      RMISS:   next_state = fill_done ? IDLE : RMISS;
      default: next_state = IDLE;
    endcase
  end

  assign core_wait = (state != IDLE);

  // Line valid bits
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (fill_done) begin
      valid[index] <= 1'b1;
    end
  end

  // ==========================================================
  // Refill path
  // ==========================================================
  // Held until the arbiter answers with a grant
  always_comb begin
    mem_req.valid = (state == RMISS) && !mem_grant;
    mem_req.addr  = {addr_r[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  end

  // Beats arrive word 0 first and shift down
  assign fill_line = {mem_resp.data, line_r[LINE_WORDS-1:1]};

  always_ff @(posedge clk) begin
    if ((state == RMISS) && mem_resp.valid) begin
      line_r <= fill_line;
    end
  end

  cache_sram #(
    .entry_t(tag_t)
  ) tag_array (
    .clk  (clk),
    .index(index),
    .write(fill_done),
    .wdata(tag_r),
    .rdata(tag_rdata)
  );

  cache_sram #(
    .entry_t(line_t)
  ) data_array (
    .clk  (clk),
    .index(index),
    .write(fill_done),
    .wdata(fill_line),
    .rdata(data_rdata)
  );

  // ==========================================================
  // Core data return
  // ==========================================================
  always_ff @(posedge clk) begin
    if ((state == CHK) && hit) begin
      core_out <= data_rdata[word_sel];
    end else if (fill_done) begin
      // Forward straight from the assembled line
      core_out <= fill_line[word_sel];
    end
  end

  // ==========================================================
  // Performance counters
  // ==========================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hit_count  <= '0;
      miss_count <= '0;
      req_count  <= '0;
    end else begin
      if (take_req) begin
        req_count <= req_count + 1'b1;
      end
      if ((state == CHK) && hit) begin
        hit_count <= hit_count + 1'b1;
      end
      if (fill_done) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

endmodule

// ==== mem_arbiter.sv ====
module mem_arbiter (
  input  logic               clk,
  input  logic               rstn,
  input  bus_pkg::mem_req_t  req0,
  input  bus_pkg::mem_req_t  req1,
  output logic               grant0,
  output logic               grant1,
  output bus_pkg::mem_req_t  mem_req,
  input  bus_pkg::mem_resp_t mem_resp,
  output bus_pkg::mem_resp_t resp0,
  output bus_pkg::mem_resp_t resp1
);

  import bus_pkg::*;

  logic busy;
  logic owner;
  logic prio;
  logic pick;
  logic any_req;
  logic burst_end;

  assign any_req   = req0.valid | req1.valid;
  assign burst_end = busy && mem_resp.valid && mem_resp.last;

  // Both waiting, the priority bit decides
  always_comb begin
    if (req0.valid && req1.valid) begin
      pick = prio;
    end else begin
      pick = req1.valid;
    end
  end

  // Strobe only while the bus is free
  always_comb begin
    mem_req       = pick ? req1 : req0;
    mem_req.valid = !busy && any_req;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy  <= 1'b0;
      owner <= 1'b0;
      prio  <= 1'b0;
    end else if (!busy && any_req) begin
      busy  <= 1'b1;
      owner <= pick;
      prio  <= !pick;
    end else if (burst_end) begin
      busy <= 1'b0;
    end
  end

  assign grant0 = busy && !owner;
  assign grant1 = busy && owner;

  // Beats go to the owner only
  always_comb begin
    resp0       = mem_resp;
    resp0.valid = mem_resp.valid && grant0;
    resp0.last  = mem_resp.last && grant0;
    resp1       = mem_resp;
    resp1.valid = mem_resp.valid && grant1;
    resp1.last  = mem_resp.last && grant1;
  end

endmodule

// ==== backing_mem.sv ====
module backing_mem (
  input  logic               clk,
  input  logic               rstn,
  input  bus_pkg::mem_req_t  mem_req,
  output bus_pkg::mem_resp_t mem_resp
);

  import bus_pkg::*;
  import cache_pkg::*;

  logic [DATA_BITS-1:0] words [MEM_WORDS];

  logic                               active;
  logic [LAT_BITS-1:0]                lat_cnt;
  logic [WORD_BITS-1:0]               beat;
  logic [MEM_ADDR_BITS-WORD_BITS-1:0] line_addr;
  logic                               start;

  // Pattern is ~addr over addr, word addressed
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      words[i] = {~16'(i), 16'(i)};
    end
  end

  assign start = mem_req.valid && !active;

  always_ff @(posedge clk) begin
    if (start) begin
      line_addr <= mem_req.addr[OFFSET_BITS +: MEM_ADDR_BITS - WORD_BITS];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active  <= 1'b0;
      lat_cnt <= '0;
      beat    <= '0;
    end else if (start) begin
      active  <= 1'b1;
      lat_cnt <= LAT_BITS'(MEM_LATENCY);
      beat    <= '0;
    end else if (active) begin
      if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end else begin
        beat <= beat + 1'b1;
        if (beat == WORD_BITS'(LINE_WORDS - 1)) begin
          active <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    mem_resp.valid = active && (lat_cnt == '0);
    mem_resp.last  = mem_resp.valid && (beat == WORD_BITS'(LINE_WORDS - 1));
    mem_resp.data  = words[{line_addr, beat}];
  end

endmodule

// ==== fetch_top.sv ====
module fetch_top (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           core_req_a,
  input  logic [bus_pkg::ADDR_BITS-1:0]  core_addr_a,
  output logic                           core_wait_a,
  output logic [bus_pkg::DATA_BITS-1:0]  core_out_a,
  input  logic                           core_req_b,
  input  logic [bus_pkg::ADDR_BITS-1:0]  core_addr_b,
  output logic                           core_wait_b,
  output logic [bus_pkg::DATA_BITS-1:0]  core_out_b,
  output logic [cache_pkg::CNT_BITS-1:0] hit_count_a,
  output logic [cache_pkg::CNT_BITS-1:0] miss_count_a,
  output logic [cache_pkg::CNT_BITS-1:0] req_count_a,
  output logic [cache_pkg::CNT_BITS-1:0] hit_count_b,
  output logic [cache_pkg::CNT_BITS-1:0] miss_count_b,
  output logic [cache_pkg::CNT_BITS-1:0] req_count_b
);

  import bus_pkg::*;

  mem_req_t  req_a, req_b, bus_req;
  mem_resp_t resp_a, resp_b, bus_resp;
  logic      grant_a, grant_b;

  // ==========================================================
  // Two peer caches
  // ==========================================================
  icache icache_a (
    .clk       (clk),
    .rstn      (rstn),
    .core_req  (core_req_a),
    .core_addr (core_addr_a),
    .core_wait (core_wait_a),
    .core_out  (core_out_a),
    .mem_req   (req_a),
    .mem_grant (grant_a),
    .mem_resp  (resp_a),
    .hit_count (hit_count_a),
    .miss_count(miss_count_a),
    .req_count (req_count_a)
  );

  icache icache_b (
    .clk       (clk),
    .rstn      (rstn),
    .core_req  (core_req_b),
    .core_addr (core_addr_b),
    .core_wait (core_wait_b),
    .core_out  (core_out_b),
    .mem_req   (req_b),
    .mem_grant (grant_b),
    .mem_resp  (resp_b),
    .hit_count (hit_count_b),
    .miss_count(miss_count_b),
    .req_count (req_count_b)
  );

  // ==========================================================
  // Shared refill bus
  // ==========================================================
  mem_arbiter arbiter (
    .clk     (clk),
    .rstn    (rstn),
    .req0    (req_a),
    .req1    (req_b),
    .grant0  (grant_a),
    .grant1  (grant_b),
    .mem_req (bus_req),
    .mem_resp(bus_resp),
    .resp0   (resp_a),
    .resp1   (resp_b)
  );

  backing_mem memory (
    .clk     (clk),
    .rstn    (rstn),
    .mem_req (bus_req),
    .mem_resp(bus_resp)
  );

endmodule

// ==== fetch_props.sv ====
module arbiter_props (
  input logic               clk,
  input logic               rstn,
  input logic               grant0,
  input logic               grant1,
  input bus_pkg::mem_resp_t mem_resp
);

  timeunit 1ns;
  timeprecision 100ps;

  // ==========================================================
  // Bus ownership
  // ==========================================================
  one_owner: assert property (@(posedge clk) disable iff (!rstn)
    !(grant0 && grant1))
    else $error("Both grants are high");

  // Held for the whole burst
  grant0_held: assert property (@(posedge clk) disable iff (!rstn)
    grant0 && !(mem_resp.valid && mem_resp.last) |=> grant0)
    else $error("grant0 dropped before the last beat");

  grant1_held: assert property (@(posedge clk) disable iff (!rstn)
    grant1 && !(mem_resp.valid && mem_resp.last) |=> grant1)
    else $error("grant1 dropped before the last beat");

  beat_in_grant: assert property (@(posedge clk) disable iff (!rstn)
    mem_resp.valid |-> (grant0 || grant1))
    else $error("Response beat without a grant");

  no_grant_after_reset: assert property (@(posedge clk)
    $rose(rstn) |-> !grant0 && !grant1)
    else $error("Grant in the first cycle after reset");

endmodule

bind mem_arbiter arbiter_props arbiter_checks (
  .clk     (clk),
  .rstn    (rstn),
  .grant0  (grant0),
  .grant1  (grant1),
  .mem_resp(mem_resp)
);

// ==== fetch_tb.sv ====
module fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;
  import cache_pkg::*;

  localparam int NUM_FETCH    = 300;
  localparam int NUM_DIRECTED = 4;
  // About 20 worst-case cycles per fetch, doubled
  localparam int TIMEOUT_CYCLES = NUM_FETCH * 20 * 2;
  // Word aligned, 1 KB window
  localparam logic [ADDR_BITS-1:0] WINDOW_MASK = 32'h0000_03fc;
  // Strobe cycle, memory latency, four beats
  localparam int MIN_MISS_WAIT = 1 + MEM_LATENCY + LINE_WORDS;

  logic                 clk;
  logic                 rstn;
  logic                 core_req_a;
  logic [ADDR_BITS-1:0] core_addr_a;
  logic                 core_wait_a;
  logic [DATA_BITS-1:0] core_out_a;
  logic                 core_req_b;
  logic [ADDR_BITS-1:0] core_addr_b;
  logic                 core_wait_b;
  logic [DATA_BITS-1:0] core_out_b;
  logic [CNT_BITS-1:0]  hit_count_a;
  logic [CNT_BITS-1:0]  miss_count_a;
  logic [CNT_BITS-1:0]  req_count_a;
  logic [CNT_BITS-1:0]  hit_count_b;
  logic [CNT_BITS-1:0]  miss_count_b;
  logic [CNT_BITS-1:0]  req_count_b;

  integer seed;
  int     cycle_cnt;
  int     data_errs;
  int     timing_errs;
  int     status_errs;

  logic [ADDR_BITS-1:0] addr_list [2][NUM_FETCH];

  // Reference model of tags and valid bits
  tag_t model_tag    [2][LINES];
  logic model_valid  [2][LINES];
  int   model_hits   [2];
  int   model_misses [2];

  // Fetch in flight on each port
  logic [ADDR_BITS-1:0] exp_addr  [2];
  logic [DATA_BITS-1:0] exp_word  [2];
  logic                 exp_hit   [2];
  int                   fetch_num [2];
  logic                 prev_wait [2];
  int                   wait_len  [2];
  int                   done_cnt  [2];

  fetch_top DUT (
    .clk         (clk),
    .rstn        (rstn),
    .core_req_a  (core_req_a),
    .core_addr_a (core_addr_a),
    .core_wait_a (core_wait_a),
    .core_out_a  (core_out_a),
    .core_req_b  (core_req_b),
    .core_addr_b (core_addr_b),
    .core_wait_b (core_wait_b),
    .core_out_b  (core_out_b),
    .hit_count_a (hit_count_a),
    .miss_count_a(miss_count_a),
    .req_count_a (req_count_a),
    .hit_count_b (hit_count_b),
    .miss_count_b(miss_count_b),
    .req_count_b (req_count_b)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================
  // Reference model
  // ==========================================================
  // Upper half inverted word address, lower half the address
  function automatic logic [DATA_BITS-1:0] expected_word(input logic [ADDR_BITS-1:0] addr);
    logic [15:0] waddr;
    waddr = 16'((addr >> 2) % MEM_WORDS);
    return {~waddr, waddr};
  endfunction

  // Direct-mapped lookup, a miss refills the line
  function automatic logic lookup_model(input int port, input logic [ADDR_BITS-1:0] addr);
    logic [INDEX_BITS-1:0] idx;
    tag_t                  tag;
    logic                  hit;
    idx = addr[OFFSET_BITS +: INDEX_BITS];
    tag = addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    hit = model_valid[port][idx] && (model_tag[port][idx] == tag);
    if (hit) begin
      model_hits[port]++;
    end else begin
      model_misses[port]++;
      model_valid[port][idx] = 1'b1;
      model_tag[port][idx]   = tag;
    end
    return hit;
  endfunction

  // Cold line, same line again, conflicting tag, evicted line
  function automatic logic [ADDR_BITS-1:0] directed_addr(input int port, input int n);
    logic [ADDR_BITS-1:0] base;
    base = (port == 0) ? 32'h040 : 32'h080;
    case (n)
      1:       return base + 32'h8;
      2:       return base + 32'h100;
      default: return base;
    endcase
  endfunction

  // ==========================================================
  // Stimulus
  // ==========================================================
  task automatic drive_port(input int port, input logic req, input logic [ADDR_BITS-1:0] addr);
    if (port == 0) begin
      core_req_a  <= req;
      core_addr_a <= addr;
    end else begin
      core_req_b  <= req;
      core_addr_b <= addr;
    end
  endtask

  task automatic do_fetch(input int port, input int n, input logic [ADDR_BITS-1:0] addr);
    logic busy;
    @(posedge clk);
    exp_addr[port]  = addr;
    exp_word[port]  = expected_word(addr);
    exp_hit[port]   = lookup_model(port, addr);
    fetch_num[port] = n;
    drive_port(port, 1'b1, addr);
    // Taken on this edge, the cache is out of IDLE
    @(posedge clk);
    drive_port(port, 1'b0, addr);
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = (port == 0) ? core_wait_a : core_wait_b;
    end
  endtask

  task automatic run_port(input int port);
    for (int n = 0; n < NUM_FETCH; n++) begin
      do_fetch(port, n, addr_list[port][n]);
    end
  endtask

  // ==========================================================
  // Checking
  // ==========================================================
  task automatic expect_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %0d actual %0d", name, expected, actual);
      status_errs++;
    end
  endtask

  task automatic check_result(input int port, input logic [DATA_BITS-1:0] actual);
    string name;
    name = $sformatf("port_%s fetch %0d addr %h", (port == 0) ? "a" : "b",
                     fetch_num[port], exp_addr[port]);
    if (actual !== exp_word[port]) begin
      $display("Fail %s data: expected %h actual %h", name, exp_word[port], actual);
      data_errs++;
    end
    if (exp_hit[port] && wait_len[port] != 1) begin
      $display("Fail %s hit wait: expected 1 actual %0d", name, wait_len[port]);
      timing_errs++;
    end
    if (!exp_hit[port] && wait_len[port] < MIN_MISS_WAIT) begin
      $display("Fail %s miss wait: expected at least %0d actual %0d", name,
               MIN_MISS_WAIT, wait_len[port]);
      timing_errs++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    logic                 w;
    logic [DATA_BITS-1:0] actual;
    for (int p = 0; p < 2; p++) begin
      w      = (p == 0) ? core_wait_a : core_wait_b;
      actual = (p == 0) ? core_out_a : core_out_b;
      if (rstn && w) begin
        wait_len[p]++;
      end else if (rstn && prev_wait[p]) begin
        check_result(p, actual);
        wait_len[p] = 0;
        done_cnt[p]++;
      end
      prev_wait[p] = w;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run timed out after %0d cycles with fetches still pending", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    seed        = 32'h8698_8014;
    data_errs   = 0;
    timing_errs = 0;
    status_errs = 0;
    rstn        = 1'b0;
    core_req_a  = 1'b0;
    core_addr_a = '0;
    core_req_b  = 1'b0;
    core_addr_b = '0;
    for (int p = 0; p < 2; p++) begin
      model_hits[p]   = 0;
      model_misses[p] = 0;
      prev_wait[p]    = 1'b0;
      wait_len[p]     = 0;
      done_cnt[p]     = 0;
      fetch_num[p]    = 0;
      for (int i = 0; i < LINES; i++) begin
        model_valid[p][i] = 1'b0;
        model_tag[p][i]   = '0;
      end
    end
    for (int n = 0; n < NUM_FETCH; n++) begin
      for (int p = 0; p < 2; p++) begin
        if (n < NUM_DIRECTED) begin
          addr_list[p][n] = directed_addr(p, n);
        end else begin
          addr_list[p][n] = $random(seed) & WINDOW_MASK;
        end
      end
    end

    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    expect_value("reset core_wait_a", 0, {31'b0, core_wait_a});
    expect_value("reset core_wait_b", 0, {31'b0, core_wait_b});
    expect_value("reset hit_count_a", 0, hit_count_a);
    expect_value("reset miss_count_a", 0, miss_count_a);
    expect_value("reset req_count_a", 0, req_count_a);
    expect_value("reset hit_count_b", 0, hit_count_b);
    expect_value("reset miss_count_b", 0, miss_count_b);
    expect_value("reset req_count_b", 0, req_count_b);

    // Both ports start on cold lines at the same time
    fork
      run_port(0);
      run_port(1);
    join
    repeat (2) @(negedge clk);

    expect_value("port_a completed fetches", NUM_FETCH, done_cnt[0]);
    expect_value("port_b completed fetches", NUM_FETCH, done_cnt[1]);
    expect_value("port_a req_count", NUM_FETCH, req_count_a);
    expect_value("port_a hit_count", model_hits[0], hit_count_a);
    expect_value("port_a miss_count", model_misses[0], miss_count_a);
    expect_value("port_b req_count", NUM_FETCH, req_count_b);
    expect_value("port_b hit_count", model_hits[1], hit_count_b);
    expect_value("port_b miss_count", model_misses[1], miss_count_b);

    $display("Errors: data %0d, timing %0d, status %0d", data_errs, timing_errs, status_errs);
    if (data_errs + timing_errs + status_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
bus_pkg.sv
cache_pkg.sv
cache_sram.sv
icache.sv
mem_arbiter.sv
backing_mem.sv
fetch_top.sv
fetch_props.sv
fetch_tb.sv

// ==== Makefile ====
TOP = fetch_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qx "sim passed" sim.log || { echo "pass message not found in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
